//--- source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // Cache geometry
    localparam int XLEN            = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int NUM_WAYS        = 2;
    localparam int NUM_SETS        = 128;
    localparam int TAG_BITS        = 21;
    localparam int INDEX_BITS      = 7;
    localparam int WORD_OFF_BITS   = 2;
    localparam int BYTE_OFF_BITS   = 2;
    localparam int BLOCK_OFF_BITS  = WORD_OFF_BITS + BYTE_OFF_BITS;

    // Backing store of 16 KB in blocks
    localparam int MEM_BLOCKS = 1024;

    localparam logic [2:0] FUNCT3_B  = 3'b000;
    localparam logic [2:0] FUNCT3_H  = 3'b001;
    localparam logic [2:0] FUNCT3_W  = 3'b010;
    localparam logic [2:0] FUNCT3_BU = 3'b100;
    localparam logic [2:0] FUNCT3_HU = 3'b101;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } load_size_e;

    typedef struct packed {
        load_size_e size;
        logic       is_unsigned;
    } load_kind_t;

    // Word 0 sits in the low bits
    typedef logic [WORDS_PER_BLOCK-1:0][XLEN-1:0] block_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]      tag;
        logic [INDEX_BITS-1:0]    index;
        logic [WORD_OFF_BITS-1:0] word_off;
        logic [BYTE_OFF_BITS-1:0] byte_off;
        logic [XLEN/8-1:0]        byte_en;
        logic [XLEN-1:0]          store_data;
        load_kind_t               kind;
    } dcache_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
        block_t          data;
    } write_back_t;

endpackage

`default_nettype wire

//--- source/access_decode.sv
`timescale 1ns/1ps
`default_nettype none

module access_decode (
    input  logic                          req_rd,
    input  logic                          req_wr,
    input  logic [dcache_pkg::XLEN-1:0]   addr,
    input  logic [dcache_pkg::XLEN-1:0]   write_data,
    input  logic [2:0]                    funct3,
    output dcache_pkg::dcache_req_t       req
);
    import dcache_pkg::*;

    logic [XLEN/8-1:0] lane_mask;
    logic [XLEN-1:0]   lane_data;
    logic [4:0]        shift;

    assign shift = {addr[1:0], 3'b000};

    always_comb begin
        case (funct3)
            FUNCT3_B, FUNCT3_BU: begin
                lane_mask = 4'b0001 << addr[1:0];
                lane_data = {24'b0, write_data[7:0]} << shift;
            end
            FUNCT3_H, FUNCT3_HU: begin
                // Halfword lane picked by byte offset bit 1
                lane_mask = addr[1] ? 4'b1100 : 4'b0011;
                lane_data = addr[1] ? {write_data[15:0], 16'b0} : {16'b0, write_data[15:0]};
            end
            default: begin
                lane_mask = 4'b1111;
                lane_data = write_data;
            end
        endcase
    end

    always_comb begin
        req.tag        = addr[XLEN-1 -: TAG_BITS];
        req.index      = addr[BLOCK_OFF_BITS +: INDEX_BITS];
        req.word_off   = addr[BYTE_OFF_BITS +: WORD_OFF_BITS];
        req.byte_off   = addr[BYTE_OFF_BITS-1:0];
        // No lanes are touched unless this is a store
        req.byte_en    = req_wr ? lane_mask : '0;
        req.store_data = lane_data;
        req.kind       = '{size: SIZE_W, is_unsigned: 1'b0};
        if (req_rd && !req_wr) begin
            case (funct3)
                FUNCT3_B:  req.kind = '{size: SIZE_B, is_unsigned: 1'b0};
                FUNCT3_H:  req.kind = '{size: SIZE_H, is_unsigned: 1'b0};
                FUNCT3_BU: req.kind = '{size: SIZE_B, is_unsigned: 1'b1};
                FUNCT3_HU: req.kind = '{size: SIZE_H, is_unsigned: 1'b1};
                default:   req.kind = '{size: SIZE_W, is_unsigned: 1'b0};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_core.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_core (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rd_en,
    input  logic                          wr_en,
    input  dcache_pkg::dcache_req_t       req,
    input  dcache_pkg::block_t            refill,
    output logic                          hit,
    output logic [dcache_pkg::XLEN-1:0]   hit_word,
    output logic [dcache_pkg::XLEN-1:0]   refill_addr,
    output dcache_pkg::write_back_t       write_back
);
    import dcache_pkg::*;

    localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    // Arrays indexed by [set][way]
    logic [TAG_BITS-1:0] tag_array  [NUM_SETS][NUM_WAYS];
    block_t              data_array [NUM_SETS][NUM_WAYS];
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty;
    logic [NUM_SETS-1:0][WAY_BITS-1:0] next_way;

    logic [NUM_WAYS-1:0] way_hit;
    logic [WAY_BITS-1:0] hit_way;
    logic [WAY_BITS-1:0] victim;
    logic                access;
    logic                miss;
    block_t              fill_block;

    logic                wb_valid;
    logic [XLEN-1:0]     wb_addr;
    block_t              wb_data;

    function automatic logic [XLEN-1:0] merge_bytes(
        input logic [XLEN-1:0]   old_word,
        input logic [XLEN-1:0]   new_word,
        input logic [XLEN/8-1:0] be
    );
        logic [XLEN-1:0] result;
        result = old_word;
        for (int b = 0; b < XLEN/8; b++) begin
            if (be[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    always_comb begin
        way_hit = '0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid[req.index][w] && (tag_array[req.index][w] == req.tag)) begin
                way_hit[w] = 1'b1;
                hit_way    = WAY_BITS'(w);
            end
        end
    end

    assign access   = rd_en || wr_en;
    assign miss     = access && !(|way_hit);
    assign hit      = access && (|way_hit);
    assign victim   = next_way[req.index];
    assign hit_word = data_array[req.index][hit_way][req.word_off];

    assign refill_addr = {req.tag, req.index, {BLOCK_OFF_BITS{1'b0}}};

    // Store bytes go straight into the incoming block on a write miss
    always_comb begin
        fill_block = refill;
        if (wr_en) begin
            fill_block[req.word_off] = merge_bytes(refill[req.word_off], req.store_data,
                                                   req.byte_en);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid    <= '0;
            dirty    <= '0;
            next_way <= '0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= 1'b0;
            if (miss) begin
                valid[req.index][victim] <= 1'b1;
                dirty[req.index][victim] <= wr_en;
                next_way[req.index]      <= victim + 1'b1;
                wb_valid <= valid[req.index][victim] && dirty[req.index][victim];
            end else if (wr_en) begin
                dirty[req.index][hit_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            tag_array[req.index][victim]  <= req.tag;
            data_array[req.index][victim] <= fill_block;
            // Victim block is captured whether or not it is dirty
            wb_addr <= {tag_array[req.index][victim], req.index, {BLOCK_OFF_BITS{1'b0}}};
            wb_data <= data_array[req.index][victim];
        end else if (wr_en) begin
            data_array[req.index][hit_way][req.word_off] <=
                merge_bytes(hit_word, req.store_data, req.byte_en);
        end
    end

    always_comb begin
        write_back.valid = wb_valid;
        write_back.addr  = wb_addr;
        write_back.data  = wb_data;
    end

endmodule

`default_nettype wire

//--- source/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  dcache_pkg::dcache_req_t       req,
    input  logic [dcache_pkg::XLEN-1:0]   hit_word,
    output logic [dcache_pkg::XLEN-1:0]   load_data
);
    import dcache_pkg::*;

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic        byte_sign;
    logic        half_sign;

    assign load_byte = hit_word[{req.byte_off, 3'b000} +: 8];
    assign load_half = hit_word[{req.byte_off[1], 4'b0000} +: 16];

    // Unsigned loads fill with zeros
    assign byte_sign = load_byte[7] && !req.kind.is_unsigned;
    assign half_sign = load_half[15] && !req.kind.is_unsigned;

    always_comb begin
        case (req.kind.size)
            SIZE_B:  load_data = {{(XLEN-8){byte_sign}}, load_byte};
            SIZE_H:  load_data = {{(XLEN-16){half_sign}}, load_half};
            default: load_data = hit_word;
        endcase
    end

endmodule

`default_nettype wire

//--- source/backing_memory.sv
`timescale 1ns/1ps
`default_nettype none

module backing_memory (
    input  logic                          clk,
    input  logic [dcache_pkg::XLEN-1:0]   refill_addr,
    output dcache_pkg::block_t            refill,
    input  dcache_pkg::write_back_t       write_back
);
    import dcache_pkg::*;

    localparam int MEM_IDX_BITS = $clog2(MEM_BLOCKS);

    block_t mem [MEM_BLOCKS];

    logic [MEM_IDX_BITS-1:0] rd_idx;
    logic [MEM_IDX_BITS-1:0] wb_idx;
    logic                    forward;

    // Upper address bits alias onto the same blocks
    assign rd_idx = refill_addr[BLOCK_OFF_BITS +: MEM_IDX_BITS];
    assign wb_idx = write_back.addr[BLOCK_OFF_BITS +: MEM_IDX_BITS];

    // Pending write-back not yet in the array
    assign forward = write_back.valid && (wb_idx == rd_idx);

    assign refill = forward ? write_back.data : mem[rd_idx];

    always_ff @(posedge clk) begin
        if (write_back.valid) begin
            mem[wb_idx] <= write_back.data;
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rd_en,
    input  logic                          wr_en,
    input  logic [dcache_pkg::XLEN-1:0]   addr,
    input  logic [dcache_pkg::XLEN-1:0]   write_data,
    input  logic [2:0]                    funct3,
    output logic                          hit,
    output logic [dcache_pkg::XLEN-1:0]   load_data,
    output dcache_pkg::write_back_t       write_back
);
    import dcache_pkg::*;

    dcache_req_t     req;
    block_t          refill;
    logic [XLEN-1:0] refill_addr;
    logic [XLEN-1:0] hit_word;

    access_decode u_decode (
        .req_rd     (rd_en),
        .req_wr     (wr_en),
        .addr       (addr),
        .write_data (write_data),
        .funct3     (funct3),
        .req        (req)
    );

    dcache_core u_core (
        .clk         (clk),
        .reset       (reset),
        .rd_en       (rd_en),
        .wr_en       (wr_en),
        .req         (req),
        .refill      (refill),
        .hit         (hit),
        .hit_word    (hit_word),
        .refill_addr (refill_addr),
        .write_back  (write_back)
    );

    load_align u_align (
        .req       (req),
        .hit_word  (hit_word),
        .load_data (load_data)
    );

    backing_memory u_mem (
        .clk         (clk),
        .refill_addr (refill_addr),
        .refill      (refill),
        .write_back  (write_back)
    );

endmodule

`default_nettype wire

//--- tb/tb_dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top;
    import dcache_pkg::*;

    localparam int LOAD_TIMEOUT = 8;

    logic            clk = 1'b0;
    logic            reset = 1'b1;
    logic            rd_en = 1'b0;
    logic            wr_en = 1'b0;
    logic [XLEN-1:0] addr = '0;
    logic [XLEN-1:0] write_data = '0;
    logic [2:0]      funct3 = FUNCT3_W;
    logic            hit;
    logic [XLEN-1:0] load_data;
    write_back_t     write_back;

    // Byte image of everything stored and a shadow of tags and pointers
    logic [7:0]          ref_mem [logic [XLEN-1:0]];
    bit [TAG_BITS-1:0]   m_tag [NUM_SETS][NUM_WAYS];
    bit                  m_valid [NUM_SETS][NUM_WAYS];
    bit                  m_dirty [NUM_SETS][NUM_WAYS];
    bit                  m_ptr [NUM_SETS];
    write_back_t         exp_wb;
    logic [XLEN*WORDS_PER_BLOCK-1:0] exp_wb_mask;
    logic [31:0]         lcg_state = 32'hab0e3fb5;
    int                  checks = 0;
    int                  errors = 0;

    dcache_top UUT (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_flag(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: got %h expected %h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] act,
                              input logic [XLEN-1:0] exp, input logic [XLEN-1:0] mask);
        checks++;
        if (((act ^ exp) & mask) !== '0) begin
            errors++;
            $display("ERR %s: got %h expected %h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic check_write_back(input write_back_t act, input write_back_t exp,
                                    input logic [XLEN*WORDS_PER_BLOCK-1:0] mask);
        checks++;
        if (act.valid !== exp.valid || (exp.valid && (act.addr !== exp.addr ||
                ((act.data ^ exp.data) & mask) !== '0))) begin
            errors++;
            $display("ERR write_back: got %h %h %h expected %h %h %h at %0t", act.valid,
                     act.addr, act.data, exp.valid, exp.addr, exp.data, $time);
        end
    endtask

    // Steps the shadow cache by one access and sets the expected write-back
    task automatic model_step(input logic [XLEN-1:0] a, input bit is_store, output bit exp_hit);
        logic [INDEX_BITS-1:0] idx;
        logic [TAG_BITS-1:0]   tag;
        logic [XLEN-1:0]       vaddr;
        int                    way;
        idx = a[4 +: INDEX_BITS];
        tag = a[XLEN-1 -: TAG_BITS];
        exp_hit = 1'b0;
        way = 0;
        exp_wb = '0;
        exp_wb_mask = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                exp_hit = 1'b1;
                way = w;
            end
        end
        if (exp_hit) begin
            if (is_store)
                m_dirty[idx][way] = 1'b1;
        end else begin
            way = int'(m_ptr[idx]);
            vaddr = {m_tag[idx][way], idx, 4'b0000};
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                exp_wb.valid = 1'b1;
                exp_wb.addr = vaddr;
                for (int b = 0; b < 16; b++) begin
                    if (ref_mem.exists(vaddr + b)) begin
                        exp_wb.data[b/4][(b%4)*8 +: 8] = ref_mem[vaddr + b];
                        exp_wb_mask[b*8 +: 8] = 8'hff;
                    end
                end
            end
            m_tag[idx][way] = tag;
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = is_store;
            m_ptr[idx] = ~m_ptr[idx];
        end
    endtask

    task automatic expected_load(input logic [XLEN-1:0] a, input logic [2:0] f3,
                                 output logic [XLEN-1:0] exp, output logic [XLEN-1:0] mask);
        logic [XLEN-1:0] raw;
        bit              known;
        int              n;
        n = (f3 == FUNCT3_W) ? 4 : (f3 == FUNCT3_H || f3 == FUNCT3_HU) ? 2 : 1;
        raw = '0;
        known = 1'b1;
        for (int i = 0; i < n; i++) begin
            if (ref_mem.exists(a + i))
                raw[i*8 +: 8] = ref_mem[a + i];
            else
                known = 1'b0;
        end
        case (f3)
            FUNCT3_B: exp = {{24{raw[7]}}, raw[7:0]};
            FUNCT3_H: exp = {{16{raw[15]}}, raw[15:0]};
            default:  exp = raw;
        endcase
        mask = known ? '1 : '0;
    endtask

    task automatic do_store(input logic [XLEN-1:0] a, input logic [XLEN-1:0] d,
                            input logic [2:0] f3);
        bit exp_hit;
        int n;
        n = (f3 == FUNCT3_W) ? 4 : (f3 == FUNCT3_H) ? 2 : 1;
        model_step(a, 1'b1, exp_hit);
        for (int i = 0; i < n; i++)
            ref_mem[a + i] = d[i*8 +: 8];
        addr = a;
        write_data = d;
        funct3 = f3;
        wr_en = 1'b1;
        @(negedge clk);
        check_flag("hit", hit, exp_hit);
        @(posedge clk);
        #2;
        wr_en = 1'b0;
        check_write_back(write_back, exp_wb, exp_wb_mask);
    endtask

    task automatic do_load(input logic [XLEN-1:0] a, input logic [2:0] f3);
        logic [XLEN-1:0] exp;
        logic [XLEN-1:0] mask;
        bit              exp_hit;
        bit              done;
        int              cycles;
        expected_load(a, f3, exp, mask);
        addr = a;
        funct3 = f3;
        rd_en = 1'b1;
        done = 1'b0;
        cycles = 0;
        while (!done && cycles < LOAD_TIMEOUT) begin
            model_step(a, 1'b0, exp_hit);
            @(negedge clk);
            check_flag("hit", hit, exp_hit);
            if (hit === 1'b1) begin
                check_word("load_data", load_data, exp, mask);
                done = 1'b1;
            end
            @(posedge clk);
            #2;
            check_write_back(write_back, exp_wb, exp_wb_mask);
            cycles++;
        end
        rd_en = 1'b0;
        if (!done) begin
            errors++;
            $display("Load from address %h never hit within %0d cycles", a, LOAD_TIMEOUT);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            check_write_back(write_back, '0, '0);
        end
    endtask

    task automatic apply_reset(input int cycles);
        logic [XLEN-1:0] baddr;
        reset = 1'b1;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                // Dirty lines never reached memory
                baddr = {m_tag[s][w], INDEX_BITS'(s), 4'b0000};
                if (m_valid[s][w] && m_dirty[s][w])
                    for (int b = 0; b < 16; b++)
                        ref_mem.delete(baddr + b);
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
            m_ptr[s] = 1'b0;
        end
        repeat (cycles) @(posedge clk);
        #2;
        reset = 1'b0;
    endtask

    task automatic test_byte_lanes();
        logic [XLEN-1:0] a;
        a = 32'h0000_0104;
        do_store(a, next_random(), FUNCT3_W);
        do_store(a + 2, next_random(), FUNCT3_H);
        do_store(a + 1, next_random(), FUNCT3_B);
        do_load(a, FUNCT3_W);
        for (int o = 0; o < 4; o += 2) begin
            do_load(a + o, FUNCT3_H);
            do_load(a + o, FUNCT3_HU);
        end
        for (int o = 0; o < 4; o++) begin
            do_load(a + o, FUNCT3_B);
            do_load(a + o, FUNCT3_BU);
        end
    endtask

    task automatic test_dirty_eviction();
        for (int w = 0; w < WORDS_PER_BLOCK; w++)
            do_store(32'h200 + 4 * w, next_random(), FUNCT3_W);
        do_store(32'ha00, next_random(), FUNCT3_W);
        // Third tag in set 0x20 pushes out block 0x200
        do_store(32'h1200, next_random(), FUNCT3_W);
        idle(1);
    endtask

    task automatic test_load_miss();
        do_load(32'h208, FUNCT3_W);
        do_load(32'h208, FUNCT3_W);
    endtask

    task automatic test_forwarding();
        do_store(32'h300, next_random(), FUNCT3_W);
        do_store(32'h30c, next_random(), FUNCT3_W);
        do_store(32'hb00, next_random(), FUNCT3_W);
        do_store(32'h1300, next_random(), FUNCT3_W);
        // Refill while 0x300 is still on its way out
        do_load(32'h300, FUNCT3_W);
        do_load(32'h30c, FUNCT3_W);
        idle(3);
        do_load(32'hb00, FUNCT3_W);
        do_load(32'h1300, FUNCT3_W);
        idle(2);
        do_load(32'h300, FUNCT3_W);
    endtask

    task automatic test_clean_eviction();
        // Set 0x30 holds only clean lines whose data sits in memory
        do_load(32'hb00, FUNCT3_W);
        do_load(32'h1300, FUNCT3_W);
        do_load(32'h300, FUNCT3_W);
    endtask

    task automatic test_reset_reload();
        do_load(32'h208, FUNCT3_W);
        apply_reset(4);
        do_load(32'h208, FUNCT3_W);
        do_load(32'h30c, FUNCT3_W);
    endtask

    initial begin
        apply_reset(16);
        test_byte_lanes();
        test_dirty_eviction();
        test_load_miss();
        test_forwarding();
        test_clean_eviction();
        test_reset_reload();
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache_top.f
source/dcache_pkg.sv
source/access_decode.sv
source/dcache_core.sv
source/load_align.sv
source/backing_memory.sv
source/dcache_top.sv
tb/tb_dcache_top.sv

//--- Makefile
TOP = tb_dcache_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f dcache_top.f --top-module $(TOP)

sim:
	verilator --binary --timing -f dcache_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
